//--- verilog/hazard_pkg.sv
// pipeline hazard definitions
package hazard_pkg;

    // general register index.
    typedef logic [4:0] reg_addr_t;

    // decode class of the instruction held in ID.
    typedef logic [3:0] id_class_t;

    localparam id_class_t CLASS_OTHER   = 4'd0;
    localparam id_class_t CLASS_BRANCH  = 4'd1;
    localparam id_class_t CLASS_JALR    = 4'd2;
    localparam id_class_t CLASS_FENCE_I = 4'd3;
    localparam id_class_t CLASS_EBREAK  = 4'd4;

    // writeback select, WB_EXE up to WB_CSRRWI write rd.
    typedef logic [3:0] wb_sel_t;

    localparam wb_sel_t WB_NONE    = 4'd0;
    localparam wb_sel_t WB_EXE     = 4'd1;
    localparam wb_sel_t WB_MEM     = 4'd2;
    localparam wb_sel_t WB_IMM     = 4'd3;
    localparam wb_sel_t WB_SNPC    = 4'd4;
    localparam wb_sel_t WB_CSRRW   = 4'd5;
    localparam wb_sel_t WB_CSRRS   = 4'd6;
    localparam wb_sel_t WB_CSRRWI  = 4'd7;
    localparam wb_sel_t WB_ECALL   = 4'd8;
    localparam wb_sel_t WB_EBREAK  = 4'd9;
    localparam wb_sel_t WB_ILLEGAL = 4'd10;

    // execute operation.
    typedef logic [4:0] exe_op_t;

    localparam exe_op_t EXE_NOP = 5'd0;

    // operand source kind of the execute stage.
    typedef logic [2:0] exe_src_t;

    localparam exe_src_t SRC_NOP  = 3'd0;
    localparam exe_src_t SRC_R_R  = 3'd1;
    localparam exe_src_t SRC_R_I  = 3'd2;
    localparam exe_src_t SRC_PC_I = 3'd3;

    // memory operation, only stores read rs2.
    typedef logic [3:0] mem_op_t;

    localparam mem_op_t MEM_NONE = 4'd0;
    localparam mem_op_t MEM_LB   = 4'd1;
    localparam mem_op_t MEM_LW   = 4'd2;
    localparam mem_op_t MEM_SB   = 4'd8;
    localparam mem_op_t MEM_SH   = 4'd9;
    localparam mem_op_t MEM_SW   = 4'd10;
    localparam mem_op_t MEM_SD   = 4'd11;

    // register sources checked for hazards.
    localparam int NUM_SRC     = 5;
    localparam int SRC_ID_RS1  = 0;
    localparam int SRC_ID_RS2  = 1;
    localparam int SRC_EXE_RS1 = 2;
    localparam int SRC_EXE_RS2 = 3;
    localparam int SRC_MEM_RS2 = 4;

    // older stages that can write rd, youngest first.
    localparam int NUM_WRITERS = 3;
    localparam int WR_EXE      = 0;
    localparam int WR_MEM      = 1;
    localparam int WR_WB       = 2;

endpackage

//--- verilog/source_decode.sv
// register source decode
`timescale 1ns/1ps

module source_decode
    import hazard_pkg::*;
#(
    parameter int NUM_SRC = hazard_pkg::NUM_SRC
) (
    input  id_class_t               id_class,
    input  logic                    id_valid,
    input  reg_addr_t               id_rs1,
    input  reg_addr_t               id_rs2,
    input  logic                    exe_valid,
    input  exe_op_t                 exe_op,
    input  exe_src_t                exe_src,
    input  reg_addr_t               exe_rs1,
    input  reg_addr_t               exe_rs2,
    input  logic                    mem_valid,
    input  mem_op_t                 mem_op,
    input  reg_addr_t               mem_rs2,
    output logic [NUM_SRC-1:0]      src_read,
    output reg_addr_t [NUM_SRC-1:0] src_addr
);

    logic id_rs1_read;
    logic id_rs2_read;
    logic exe_rs1_read;
    logic exe_rs2_read;
    logic mem_rs2_read;

    // branches compare both sources, jalr only needs the base.
    assign id_rs1_read = id_valid && (id_class == CLASS_BRANCH || id_class == CLASS_JALR);
    assign id_rs2_read = id_valid && (id_class == CLASS_BRANCH);

    always_comb begin
        exe_rs1_read = 1'b0;
        exe_rs2_read = 1'b0;
        if (exe_valid && exe_op != EXE_NOP) begin
            case (exe_src)
                SRC_R_R: begin
                    exe_rs1_read = 1'b1;
                    exe_rs2_read = 1'b1;
                end
                SRC_R_I: begin
                    exe_rs1_read = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    // store data is read in MEM.
    always_comb begin
        case (mem_op)
            MEM_SB, MEM_SH, MEM_SW, MEM_SD: mem_rs2_read = mem_valid;
            default:                        mem_rs2_read = 1'b0;
        endcase
    end

    assign src_read[SRC_ID_RS1]  = id_rs1_read;
    assign src_read[SRC_ID_RS2]  = id_rs2_read;
    assign src_read[SRC_EXE_RS1] = exe_rs1_read;
    assign src_read[SRC_EXE_RS2] = exe_rs2_read;
    assign src_read[SRC_MEM_RS2] = mem_rs2_read;

    assign src_addr[SRC_ID_RS1]  = id_rs1;
    assign src_addr[SRC_ID_RS2]  = id_rs2;
    assign src_addr[SRC_EXE_RS1] = exe_rs1;
    assign src_addr[SRC_EXE_RS2] = exe_rs2;
    assign src_addr[SRC_MEM_RS2] = mem_rs2;

endmodule

//--- verilog/writer_match.sv
// stage writer match
`timescale 1ns/1ps

module writer_match
    import hazard_pkg::*;
#(
    parameter int NUM_SRC = hazard_pkg::NUM_SRC
) (
    input  logic                    valid,
    input  wb_sel_t                 wb_sel,
    input  reg_addr_t               rd,
    input  reg_addr_t [NUM_SRC-1:0] src_addr,
    output logic [NUM_SRC-1:0]      match
);

    logic rd_write;

    // csr instructions also return the old value to rd.
    always_comb begin
        case (wb_sel)
            WB_EXE,
            WB_MEM,
            WB_IMM,
            WB_SNPC,
            WB_CSRRW,
            WB_CSRRS,
            WB_CSRRWI: rd_write = valid;
            default:   rd_write = 1'b0;
        endcase
    end

    // x0 is compared like any other register.
    for (genvar j = 0; j < NUM_SRC; j++) begin : g_cmp
        assign match[j] = rd_write && (src_addr[j] == rd);
    end

endmodule

//--- verilog/stall_control.sv
// pipeline stall and bubble control
`timescale 1ns/1ps

module stall_control
    import hazard_pkg::*;
#(
    parameter int NUM_SRC     = hazard_pkg::NUM_SRC,
    parameter int NUM_WRITERS = hazard_pkg::NUM_WRITERS
) (
    input  logic [NUM_SRC-1:0]                  src_read,
    input  logic [NUM_WRITERS-1:0][NUM_SRC-1:0] match,
    input  id_class_t                           id_class,
    input  logic                                id_valid,
    input  logic                                exe_valid,
    input  logic                                mem_valid,
    input  logic                                if_ok,
    input  logic                                mem_ok,
    input  logic                                redirect,
    output logic                                if_reg_enable,
    output logic                                id_reg_valid,
    output logic                                id_reg_enable,
    output logic                                exe_reg_valid,
    output logic                                exe_reg_enable,
    output logic                                mem_reg_valid,
    output logic                                mem_reg_enable,
    output logic                                wb_reg_valid
);

    // youngest writer that is still older than the stage reading the source.
    function automatic int first_writer(input int src);
        case (src)
            SRC_ID_RS1,
            SRC_ID_RS2:  first_writer = WR_EXE;
            SRC_EXE_RS1,
            SRC_EXE_RS2: first_writer = WR_MEM;
            default:     first_writer = WR_WB;
        endcase
    endfunction

    logic [NUM_SRC-1:0] src_conflict;
    logic               id_hazard;
    logic               exe_hazard;
    logic               mem_hazard;
    logic               fence_wait;
    logic               pipe_stall;

    for (genvar j = 0; j < NUM_SRC; j++) begin : g_src
        localparam int FIRST = first_writer(j);

        logic [NUM_WRITERS-1:0] writer_hit;

        for (genvar k = 0; k < NUM_WRITERS; k++) begin : g_wr
            assign writer_hit[k] = match[k][j];
        end

        // writers younger than the reader are not yet in its way.
        assign src_conflict[j] = src_read[j] && (|(writer_hit >> FIRST));
    end

    assign id_hazard  = src_conflict[SRC_ID_RS1] || src_conflict[SRC_ID_RS2];
    assign exe_hazard = src_conflict[SRC_EXE_RS1] || src_conflict[SRC_EXE_RS2];
    assign mem_hazard = src_conflict[SRC_MEM_RS2];

    // fence.i waits until older stores have left EXE and MEM.
    assign fence_wait = (id_class == CLASS_FENCE_I) && (exe_valid || mem_valid);

    // any hazard holds the front end so the reader stays in place.
    assign pipe_stall = fence_wait || !mem_ok || id_hazard || exe_hazard || mem_hazard;

    assign if_reg_enable = !pipe_stall && if_ok;
    assign id_reg_enable = !pipe_stall;

    // a taken redirect kills the fetched instruction.
    assign id_reg_valid = !(id_valid && redirect);

    assign exe_reg_valid = !((id_class == CLASS_FENCE_I) || id_hazard
                             || (id_valid && id_class == CLASS_EBREAK));

    assign exe_reg_enable = mem_ok && !exe_hazard && !mem_hazard;
    assign mem_reg_valid  = !exe_hazard;

    assign mem_reg_enable = mem_ok && !mem_hazard;
    assign wb_reg_valid   = !mem_hazard;

endmodule

//--- verilog/conflict_detector.sv
// pipeline conflict detector
`timescale 1ns/1ps

module conflict_detector
    import hazard_pkg::*;
#(
    parameter int NUM_SRC     = hazard_pkg::NUM_SRC,
    parameter int NUM_WRITERS = hazard_pkg::NUM_WRITERS
) (
    input  id_class_t id_class,
    input  logic      id_valid,
    input  reg_addr_t id_rs1,
    input  reg_addr_t id_rs2,
    input  logic      redirect,
    input  logic      if_ok,
    input  logic      exe_valid,
    input  exe_op_t   exe_op,
    input  exe_src_t  exe_src,
    input  wb_sel_t   exe_wb_sel,
    input  reg_addr_t exe_rd,
    input  reg_addr_t exe_rs1,
    input  reg_addr_t exe_rs2,
    input  logic      mem_valid,
    input  logic      mem_ok,
    input  mem_op_t   mem_op,
    input  wb_sel_t   mem_wb_sel,
    input  reg_addr_t mem_rd,
    input  reg_addr_t mem_rs2,
    input  logic      wb_valid,
    input  wb_sel_t   wb_wb_sel,
    input  reg_addr_t wb_rd,
    output logic      if_reg_enable,
    output logic      id_reg_valid,
    output logic      id_reg_enable,
    output logic      exe_reg_valid,
    output logic      exe_reg_enable,
    output logic      mem_reg_valid,
    output logic      mem_reg_enable,
    output logic      wb_reg_valid
);

    logic [NUM_SRC-1:0]                  src_read;
    reg_addr_t [NUM_SRC-1:0]             src_addr;
    logic [NUM_WRITERS-1:0][NUM_SRC-1:0] match;
    logic [NUM_WRITERS-1:0]              wr_valid;
    wb_sel_t [NUM_WRITERS-1:0]           wr_wb_sel;
    reg_addr_t [NUM_WRITERS-1:0]         wr_rd;

    source_decode #(
        .NUM_SRC(NUM_SRC)
    ) source_decode_inst (
        .id_class (id_class),
        .id_valid (id_valid),
        .id_rs1   (id_rs1),
        .id_rs2   (id_rs2),
        .exe_valid(exe_valid),
        .exe_op   (exe_op),
        .exe_src  (exe_src),
        .exe_rs1  (exe_rs1),
        .exe_rs2  (exe_rs2),
        .mem_valid(mem_valid),
        .mem_op   (mem_op),
        .mem_rs2  (mem_rs2),
        .src_read (src_read),
        .src_addr (src_addr)
    );

    // older stages in writer order.
    assign wr_valid[WR_EXE]  = exe_valid;
    assign wr_valid[WR_MEM]  = mem_valid;
    assign wr_valid[WR_WB]   = wb_valid;
    assign wr_wb_sel[WR_EXE] = exe_wb_sel;
    assign wr_wb_sel[WR_MEM] = mem_wb_sel;
    assign wr_wb_sel[WR_WB]  = wb_wb_sel;
    assign wr_rd[WR_EXE]     = exe_rd;
    assign wr_rd[WR_MEM]     = mem_rd;
    assign wr_rd[WR_WB]      = wb_rd;

    for (genvar k = 0; k < NUM_WRITERS; k++) begin : g_writer
        writer_match #(
            .NUM_SRC(NUM_SRC)
        ) writer_match_inst (
            .valid   (wr_valid[k]),
            .wb_sel  (wr_wb_sel[k]),
            .rd      (wr_rd[k]),
            .src_addr(src_addr),
            .match   (match[k])
        );
    end

    stall_control #(
        .NUM_SRC    (NUM_SRC),
        .NUM_WRITERS(NUM_WRITERS)
    ) stall_control_inst (
        .src_read      (src_read),
        .match         (match),
        .id_class      (id_class),
        .id_valid      (id_valid),
        .exe_valid     (exe_valid),
        .mem_valid     (mem_valid),
        .if_ok         (if_ok),
        .mem_ok        (mem_ok),
        .redirect      (redirect),
        .if_reg_enable (if_reg_enable),
        .id_reg_valid  (id_reg_valid),
        .id_reg_enable (id_reg_enable),
        .exe_reg_valid (exe_reg_valid),
        .exe_reg_enable(exe_reg_enable),
        .mem_reg_valid (mem_reg_valid),
        .mem_reg_enable(mem_reg_enable),
        .wb_reg_valid  (wb_reg_valid)
    );

endmodule

//--- tb/conflict_detector_assert.sv
// stall control assertions
`timescale 1ns/1ps

module conflict_detector_assert (
    input logic clk,
    input logic mem_ok,
    input logic if_reg_enable,
    input logic id_reg_enable,
    input logic exe_reg_enable,
    input logic mem_reg_enable,
    input logic id_hazard,
    input logic exe_reg_valid,
    input logic mem_hazard,
    input logic wb_reg_valid
);

    // memory back-pressure freezes every stage register.
    a_mem_ok_freeze: assert property (@(posedge clk)
        !mem_ok |-> !(if_reg_enable || id_reg_enable || exe_reg_enable || mem_reg_enable))
        else $error("stage register enabled while mem_ok is low");

    // the stalled ID instruction must not also enter EXE.
    a_id_bubble: assert property (@(posedge clk)
        id_hazard |-> !exe_reg_valid)
        else $error("id hazard without a bubble into EXE");

    a_mem_bubble: assert property (@(posedge clk)
        mem_hazard |-> !wb_reg_valid)
        else $error("mem hazard without a bubble into WB");

endmodule

//--- tb/conflict_detector_tb.sv
// conflict detector testbench
`timescale 1ns/1ps

module conflict_detector_tb
    import hazard_pkg::*;
();

    localparam int CLK_HALF       = 5;
    localparam int DRIVE_DELAY    = 1;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_TESTS      = 16;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * NUM_TESTS + 20;
    localparam int SEED           = 32'hcadd;

    // every DUT input in one record.
    typedef struct packed {
        id_class_t id_class;
        logic      id_valid;
        reg_addr_t id_rs1;
        reg_addr_t id_rs2;
        logic      redirect;
        logic      if_ok;
        logic      exe_valid;
        exe_op_t   exe_op;
        exe_src_t  exe_src;
        wb_sel_t   exe_wb_sel;
        reg_addr_t exe_rd;
        reg_addr_t exe_rs1;
        reg_addr_t exe_rs2;
        logic      mem_valid;
        logic      mem_ok;
        mem_op_t   mem_op;
        wb_sel_t   mem_wb_sel;
        reg_addr_t mem_rd;
        reg_addr_t mem_rs2;
        logic      wb_valid;
        wb_sel_t   wb_wb_sel;
        reg_addr_t wb_rd;
    } stim_t;

    logic  clk = 1'b0;
    logic  rst_n = 1'b0;
    stim_t cur;
    int    cycle_count = 0;
    int    n_tests = 0;

    stim_t      stim_tab [NUM_TESTS];
    logic [7:0] expect_tab [NUM_TESTS];
    string      name_tab [NUM_TESTS];

    logic       if_reg_enable;
    logic       id_reg_valid;
    logic       id_reg_enable;
    logic       exe_reg_valid;
    logic       exe_reg_enable;
    logic       mem_reg_valid;
    logic       mem_reg_enable;
    logic       wb_reg_valid;
    logic [7:0] out_vec;

    conflict_detector #(
        .NUM_SRC    (NUM_SRC),
        .NUM_WRITERS(NUM_WRITERS)
    ) conflict_detector_inst (
        .id_class      (cur.id_class),
        .id_valid      (cur.id_valid),
        .id_rs1        (cur.id_rs1),
        .id_rs2        (cur.id_rs2),
        .redirect      (cur.redirect),
        .if_ok         (cur.if_ok),
        .exe_valid     (cur.exe_valid),
        .exe_op        (cur.exe_op),
        .exe_src       (cur.exe_src),
        .exe_wb_sel    (cur.exe_wb_sel),
        .exe_rd        (cur.exe_rd),
        .exe_rs1       (cur.exe_rs1),
        .exe_rs2       (cur.exe_rs2),
        .mem_valid     (cur.mem_valid),
        .mem_ok        (cur.mem_ok),
        .mem_op        (cur.mem_op),
        .mem_wb_sel    (cur.mem_wb_sel),
        .mem_rd        (cur.mem_rd),
        .mem_rs2       (cur.mem_rs2),
        .wb_valid      (cur.wb_valid),
        .wb_wb_sel     (cur.wb_wb_sel),
        .wb_rd         (cur.wb_rd),
        .if_reg_enable (if_reg_enable),
        .id_reg_valid  (id_reg_valid),
        .id_reg_enable (id_reg_enable),
        .exe_reg_valid (exe_reg_valid),
        .exe_reg_enable(exe_reg_enable),
        .mem_reg_valid (mem_reg_valid),
        .mem_reg_enable(mem_reg_enable),
        .wb_reg_valid  (wb_reg_valid)
    );

    bind stall_control conflict_detector_assert conflict_detector_assert_inst (
        .clk           (conflict_detector_tb.clk),
        .mem_ok        (mem_ok),
        .if_reg_enable (if_reg_enable),
        .id_reg_enable (id_reg_enable),
        .exe_reg_enable(exe_reg_enable),
        .mem_reg_enable(mem_reg_enable),
        .id_hazard     (id_hazard),
        .exe_reg_valid (exe_reg_valid),
        .mem_hazard    (mem_hazard),
        .wb_reg_valid  (wb_reg_valid)
    );

    // outputs packed most significant first.
    assign out_vec = {if_reg_enable, id_reg_valid, id_reg_enable, exe_reg_valid,
                      exe_reg_enable, mem_reg_valid, mem_reg_enable, wb_reg_valid};

    initial begin
        forever #CLK_HALF clk = ~clk;
    end

    // reset drops just after the last reset edge.
    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    function automatic reg_addr_t random_addr();
        return reg_addr_t'($urandom());
    endfunction

    // empty pipeline with random addresses that nothing reads or writes.
    function automatic stim_t idle_stim();
        stim_t s;
        s            = '0;
        s.id_class   = CLASS_OTHER;
        s.if_ok      = 1'b1;
        s.mem_ok     = 1'b1;
        s.exe_op     = EXE_NOP;
        s.exe_src    = SRC_NOP;
        s.exe_wb_sel = WB_NONE;
        s.mem_op     = MEM_NONE;
        s.mem_wb_sel = WB_NONE;
        s.wb_wb_sel  = WB_NONE;
        s.id_rs1     = random_addr();
        s.id_rs2     = random_addr();
        s.exe_rd     = random_addr();
        s.exe_rs1    = random_addr();
        s.exe_rs2    = random_addr();
        s.mem_rd     = random_addr();
        s.mem_rs2    = random_addr();
        s.wb_rd      = random_addr();
        return s;
    endfunction

    task automatic add_test(input string name, input stim_t s, input logic [7:0] expected);
        if (n_tests < NUM_TESTS) begin
            name_tab[n_tests]   = name;
            stim_tab[n_tests]   = s;
            expect_tab[n_tests] = expected;
        end
        n_tests++;
    endtask

    task automatic compare_outputs(input string name, input logic [7:0] expected,
                                   input logic [7:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %b, actual %b", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "output mismatch");
        end
    endtask

    // expected vectors follow the stall and bubble rules by hand.
    task automatic build_table();
        stim_t s;
        s = idle_stim();
        add_test("idle", s, 8'b1111_1111);

        s            = idle_stim();
        s.id_valid   = 1'b1;
        s.id_class   = CLASS_BRANCH;
        s.id_rs1     = 5'd5;
        s.id_rs2     = 5'd6;
        s.exe_valid  = 1'b1;
        s.exe_wb_sel = WB_EXE;
        s.exe_rd     = 5'd5;
        add_test("branch_rs1_exe", s, 8'b0100_1111);
        s.exe_wb_sel = WB_ECALL;
        add_test("branch_rs1_exe_ecall", s, 8'b1111_1111);

        s           = idle_stim();
        s.id_valid  = 1'b1;
        s.id_class  = CLASS_BRANCH;
        s.id_rs1    = 5'd7;
        s.id_rs2    = 5'd9;
        s.wb_valid  = 1'b1;
        s.wb_wb_sel = WB_MEM;
        s.wb_rd     = 5'd9;
        add_test("branch_rs2_wb", s, 8'b0100_1111);

        // jalr reads only its base register.
        s            = idle_stim();
        s.id_valid   = 1'b1;
        s.id_class   = CLASS_JALR;
        s.id_rs1     = 5'd3;
        s.id_rs2     = 5'd12;
        s.exe_valid  = 1'b1;
        s.exe_wb_sel = WB_IMM;
        s.exe_rd     = 5'd12;
        add_test("jalr_rs2_ignored", s, 8'b1111_1111);

        s            = idle_stim();
        s.exe_valid  = 1'b1;
        s.exe_op     = 5'd1;
        s.exe_src    = SRC_R_R;
        s.exe_rs1    = 5'd10;
        s.exe_rs2    = 5'd11;
        s.mem_valid  = 1'b1;
        s.mem_wb_sel = WB_EXE;
        s.mem_rd     = 5'd11;
        add_test("exe_rr_rs2_mem", s, 8'b0101_0011);
        s.mem_valid  = 1'b0;
        s.exe_wb_sel = WB_EXE;
        s.exe_rd     = 5'd11;
        add_test("exe_rr_writer_in_exe", s, 8'b1111_1111);
        s.mem_valid  = 1'b1;
        s.exe_src    = SRC_PC_I;
        add_test("exe_pc_i_no_read", s, 8'b1111_1111);

        s           = idle_stim();
        s.mem_valid = 1'b1;
        s.mem_op    = MEM_SW;
        s.mem_rs2   = 5'd20;
        s.wb_valid  = 1'b1;
        s.wb_wb_sel = WB_EXE;
        s.wb_rd     = 5'd20;
        add_test("mem_sw_rs2_wb", s, 8'b0101_0100);
        s.mem_op     = MEM_LW;
        s.mem_wb_sel = WB_MEM;
        add_test("mem_lw_no_read", s, 8'b1111_1111);

        s           = idle_stim();
        s.id_valid  = 1'b1;
        s.id_class  = CLASS_FENCE_I;
        s.exe_valid = 1'b1;
        add_test("fence_i_exe_busy", s, 8'b0100_1111);
        s.exe_valid = 1'b0;
        add_test("fence_i_drained", s, 8'b1110_1111);

        s        = idle_stim();
        s.mem_ok = 1'b0;
        add_test("mem_ok_low", s, 8'b0101_0101);
        s        = idle_stim();
        s.if_ok  = 1'b0;
        add_test("if_ok_low", s, 8'b0111_1111);

        s          = idle_stim();
        s.id_valid = 1'b1;
        s.id_class = CLASS_EBREAK;
        add_test("ebreak_bubble", s, 8'b1110_1111);
        s          = idle_stim();
        s.id_valid = 1'b1;
        s.redirect = 1'b1;
        add_test("redirect_kill", s, 8'b1011_1111);
    endtask

    initial begin
        void'($urandom(SEED));
        cur = idle_stim();
        build_table();
        if (n_tests != NUM_TESTS) begin
            $display("stimulus table holds %0d entries instead of %0d", n_tests, NUM_TESTS);
            $display("*** FAILED ***");
            $fatal(1, "table size");
        end

        // all stages stay empty through reset.
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        compare_outputs("reset_idle", 8'b1111_1111, out_vec);
        wait (rst_n === 1'b1);

        for (int i = 0; i < NUM_TESTS; i++) begin
            cur = stim_tab[i];
            @(negedge clk);
            compare_outputs(name_tab[i], expect_tab[i], out_vec);
            @(posedge clk);
            #DRIVE_DELAY;
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- all.f
verilog/hazard_pkg.sv
verilog/source_decode.sv
verilog/writer_match.sv
verilog/stall_control.sv
verilog/conflict_detector.sv
tb/conflict_detector_assert.sv
tb/conflict_detector_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module conflict_detector_tb \
    -f all.f \
    -o conflict_detector_sim

output=$(./obj_dir/conflict_detector_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
else
    exit 1
fi
